// ==== design/bsk_client_recv.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_client_recv
  import param_tfhe_pkg::*;
  import bsk_ntw_common_param_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_i,
  input  bsk_pkt_t                    merged_i,
  output bsk_pkt_t                    bsk_o,
  output logic                        bsk_vld_o,
  output logic                        loop_done_o,
  output logic                        loop_err_o,
  output logic [`BSK_BATCH_NB_W-1:0]  loop_batch_nb_o
);

  localparam int BATCH_W = `BSK_BATCH_NB_W;
  localparam logic [BATCH_W-1:0] CNT_ONE = BATCH_W'(1);

  // --------------------------------------------------
  // Batch decode
  // --------------------------------------------------
  recv_state_e        state_q;
  recv_state_e        state_d;
  logic [BATCH_W-1:0] batch_cnt_q;
  logic [BATCH_W-1:0] batch_cnt_d;
  lwe_k_t             loop_q;
  logic               in_vld;
  logic               last_slot;
  logic               loop_change;
  logic               restart;

  assign in_vld      = |merged_i.avail;
  // Max unit and group closes the loop
  assign last_slot   = (&merged_i.unit) && (&merged_i.group);
  assign loop_change = (state_q == RECV_ACTIVE) && (merged_i.br_loop != loop_q);
  assign restart     = (state_q == RECV_WAIT) || loop_change;
  assign batch_cnt_d = restart ? CNT_ONE : batch_cnt_q + CNT_ONE;

  always_comb begin
    state_d = state_q;
    if (in_vld) begin
      state_d = last_slot ? RECV_WAIT : RECV_ACTIVE;
    end
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q         <= RECV_WAIT;
      batch_cnt_q     <= '0;
      bsk_vld_o       <= 1'b0;
      loop_done_o     <= 1'b0;
      loop_err_o      <= 1'b0;
      loop_batch_nb_o <= '0;
    end else begin
      state_q     <= state_d;
      bsk_vld_o   <= in_vld;
      loop_done_o <= in_vld && last_slot;
      loop_err_o  <= in_vld && loop_change;
      if (in_vld) begin
        batch_cnt_q <= batch_cnt_d;
      end
      if (in_vld && last_slot) begin
        loop_batch_nb_o <= batch_cnt_d;
      end
    end
  end

  // Loop index of the first batch, refreshed on restart
  always_ff @(posedge clk) begin
    if (in_vld && restart) begin
      loop_q <= merged_i.br_loop;
    end
  end

  // Batch passes straight to clients
  always_ff @(posedge clk) begin
    bsk_o <= merged_i;
  end

endmodule

// ==== design/bsk_inner_or_tree.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_inner_or_tree
  import bsk_ntw_common_param_pkg::*;
(
  input  logic                                clk,
  // Local servers
  input  bsk_pkt_t [`BSK_LOCAL_SRV_NB-1:0]    srv_pkt_i,
  // Side regions
  input  bsk_pkt_t                            side2_i,
  input  bsk_pkt_t                            side3_i,
  output bsk_pkt_t                            side2_o,
  output bsk_pkt_t                            side3_o,
  // Clients
  output bsk_pkt_t                            merged_o
);

  // --------------------------------------------------
  // Input register barrier
  // --------------------------------------------------
  bsk_pkt_t [`BSK_LOCAL_SRV_NB-1:0] srv_pkt_q;
  bsk_pkt_t                         side2_q;
  bsk_pkt_t                         side3_q;

  // From local servers
  always_ff @(posedge clk) begin
    srv_pkt_q <= srv_pkt_i;
  end

  // From side regions, long routes across the SLR boundary
  always_ff @(posedge clk) begin
    side2_q <= side2_i;
    side3_q <= side3_i;
  end

  // --------------------------------------------------
  // Merge
  // --------------------------------------------------
  bsk_pkt_t local_or;
  bsk_pkt_t side2_or;
  bsk_pkt_t side3_or;

  // All local servers first
  always_comb begin
    local_or = '0;
    for (int i = 0; i < `BSK_LOCAL_SRV_NB; i++) begin
      local_or = local_or | srv_pkt_q[i];
    end
  end

  // Each side gets the local merge plus its own stream
  always_comb begin
    side2_or = local_or | side2_q;
    side3_or = local_or | side3_q;
  end

  // --------------------------------------------------
  // Output register barrier
  // --------------------------------------------------
  bsk_pkt_t side2_d;
  bsk_pkt_t side3_d;
  bsk_pkt_t merged_d;

  // Back to side regions
  always_ff @(posedge clk) begin
    side2_d <= side2_or;
    side3_d <= side3_or;
  end

  // Full merge for clients
  // the local part appears on both sides, OR keeps it intact
  always_ff @(posedge clk) begin
    merged_d <= side2_d | side3_d;
  end

  assign side2_o  = side2_d;
  assign side3_o  = side3_d;
  assign merged_o = merged_d;

endmodule

// ==== design/bsk_ntw_common_param_pkg.sv ====
`include "bsk_ntw_defines.svh"

package bsk_ntw_common_param_pkg;

  import param_tfhe_pkg::*;

  // --------------------------------------------------
  // Broadcast packet
  // --------------------------------------------------
  // A non-owner drives all zeros, so packets merge by OR.
  // The packet is present when any avail bit is set.
  typedef struct packed {
    logic [`BSK_DIST_COEF_NB-1:0][`BSK_OP_W-1:0]  coef;
    logic [`BSK_DIST_COEF_NB-1:0]                 avail;
    logic [`BSK_UNIT_W-1:0]                       unit;
    logic [`BSK_GROUP_W-1:0]                      group;
    lwe_k_t                                       br_loop;
  } bsk_pkt_t;

  // --------------------------------------------------
  // Client receiver
  // --------------------------------------------------
  typedef enum logic {
    RECV_WAIT   = 1'b0,
    RECV_ACTIVE = 1'b1
  } recv_state_e;

endpackage

// ==== design/bsk_ntw_top.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_ntw_top
  import param_tfhe_pkg::*;
  import bsk_ntw_common_param_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset_i,
  // Command stream
  input  bsk_cmd_t                    cmd_i,
  // Side regions
  input  bsk_pkt_t                    side2_i,
  input  bsk_pkt_t                    side3_i,
  output bsk_pkt_t                    side2_o,
  output bsk_pkt_t                    side3_o,
  // Client
  output bsk_pkt_t                    bsk_o,
  output logic                        bsk_vld_o,
  output logic                        loop_done_o,
  output logic                        loop_err_o,
  output logic [`BSK_BATCH_NB_W-1:0]  loop_batch_nb_o
);

  bsk_pkt_t [`BSK_LOCAL_SRV_NB-1:0] srv_pkt;
  bsk_pkt_t                         merged;

  // --------------------------------------------------
  // Local key servers
  // --------------------------------------------------
  for (genvar i = 0; i < `BSK_LOCAL_SRV_NB; i++) begin : gen_srv
    bsk_server #(
      .SRV_ID (i)
    ) i_bsk_server (
      .clk       (clk),
      .reset_i   (reset_i),
      .cmd_i     (cmd_i),
      .srv_pkt_o (srv_pkt[i])
    );
  end

  // --------------------------------------------------
  // OR tree and client
  // --------------------------------------------------
  bsk_inner_or_tree i_bsk_inner_or_tree (
    .clk       (clk),
    .srv_pkt_i (srv_pkt),
    .side2_i   (side2_i),
    .side3_i   (side3_i),
    .side2_o   (side2_o),
    .side3_o   (side3_o),
    .merged_o  (merged)
  );

  bsk_client_recv i_bsk_client_recv (
    .clk             (clk),
    .reset_i         (reset_i),
    .merged_i        (merged),
    .bsk_o           (bsk_o),
    .bsk_vld_o       (bsk_vld_o),
    .loop_done_o     (loop_done_o),
    .loop_err_o      (loop_err_o),
    .loop_batch_nb_o (loop_batch_nb_o)
  );

endmodule

// ==== design/bsk_server.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_server
  import param_tfhe_pkg::*;
  import bsk_ntw_common_param_pkg::*;
#(
  parameter int SRV_ID = 0
) (
  input  logic     clk,
  input  logic     reset_i,
  input  bsk_cmd_t cmd_i,
  output bsk_pkt_t srv_pkt_o
);

  localparam int OWNER_W = `BSK_OWNER_W;
  localparam logic [OWNER_W-1:0] OWNER_ID = OWNER_W'(SRV_ID);
  // Slot is the unit plus the group bits above the owner field
  localparam int SLOT_W = `BSK_UNIT_W + `BSK_GROUP_W - OWNER_W;
  localparam int SLOT_NB = 2 ** SLOT_W;

  typedef logic [`BSK_DIST_COEF_NB-1:0][`BSK_OP_W-1:0] batch_t;

  // --------------------------------------------------
  // Command decode
  // --------------------------------------------------
  logic              owned;
  logic              load_en;
  logic              bcast_en;
  logic [SLOT_W-1:0] slot;

  assign owned    = (cmd_i.group[OWNER_W-1:0] == OWNER_ID);
  assign load_en  = owned && (cmd_i.op == BSK_OP_LOAD);
  assign bcast_en = owned && (cmd_i.op == BSK_OP_BCAST);
  assign slot     = {cmd_i.unit, cmd_i.group[`BSK_GROUP_W-1:OWNER_W]};

  // --------------------------------------------------
  // Key store
  // --------------------------------------------------
  batch_t key_mem [SLOT_NB];

  always_ff @(posedge clk) begin
    if (load_en) begin
      key_mem[slot] <= cmd_i.coef;
    end
  end

  // --------------------------------------------------
  // Broadcast read
  // --------------------------------------------------
  batch_t                  rd_coef_q;
  logic [`BSK_UNIT_W-1:0]  unit_q;
  logic [`BSK_GROUP_W-1:0] group_q;
  lwe_k_t                  br_loop_q;
  logic                    bcast_q;

  // Batch and its tag captured together
  always_ff @(posedge clk) begin
    if (bcast_en) begin
      rd_coef_q <= key_mem[slot];
      unit_q    <= cmd_i.unit;
      group_q   <= cmd_i.group;
      br_loop_q <= cmd_i.br_loop;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      bcast_q <= 1'b0;
    end else begin
      bcast_q <= bcast_en;
    end
  end

  // Zeros unless this server owns the broadcast slot
  always_comb begin
    srv_pkt_o = '0;
    if (bcast_q) begin
      srv_pkt_o.coef    = rd_coef_q;
      srv_pkt_o.avail   = '1;
      srv_pkt_o.unit    = unit_q;
      srv_pkt_o.group   = group_q;
      srv_pkt_o.br_loop = br_loop_q;
    end
  end

endmodule

// ==== design/param_tfhe_pkg.sv ====
`include "bsk_ntw_defines.svh"

package param_tfhe_pkg;

  // Loop index of the blind rotation
  typedef logic [`LWE_K_W-1:0] lwe_k_t;

  // --------------------------------------------------
  // Key network commands
  // --------------------------------------------------
  typedef enum logic [1:0] {
    BSK_OP_IDLE  = 2'd0,
    BSK_OP_LOAD  = 2'd1,
    BSK_OP_BCAST = 2'd2
  } bsk_op_e;

  // One command per cycle, coef only meaningful on LOAD
  typedef struct packed {
    bsk_op_e                                      op;
    logic [`BSK_UNIT_W-1:0]                       unit;
    logic [`BSK_GROUP_W-1:0]                      group;
    lwe_k_t                                       br_loop;
    logic [`BSK_DIST_COEF_NB-1:0][`BSK_OP_W-1:0]  coef;
  } bsk_cmd_t;

endpackage

// ==== dv/bsk_ntw_asserts.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_ntw_asserts
  import bsk_ntw_common_param_pkg::*;
(
  input logic                             clk,
  input logic                             reset_i,
  input bsk_pkt_t [`BSK_LOCAL_SRV_NB-1:0] srv_pkt_i,
  input bsk_pkt_t                         side2_i,
  input bsk_pkt_t                         side3_i,
  input bsk_pkt_t                         bsk_i,
  input logic                             bsk_vld_i,
  input logic                             loop_done_i,
  input logic                             loop_err_i
);

  // --------------------------------------------------
  // OR tree sources
  // --------------------------------------------------
  property avail_whole_p(logic [`BSK_DIST_COEF_NB-1:0] avail);
    @(posedge clk) disable iff (reset_i) (avail == '0) || (avail == '1);
  endproperty

  // Only the slot owner drives a non-zero packet
  one_src_a: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({srv_pkt_i[0] != '0, srv_pkt_i[1] != '0, side2_i != '0, side3_i != '0}))
    else $error("more than one key source active in the same cycle");

  side2_avail_a: assert property (avail_whole_p(side2_i.avail))
    else $error("partial avail bits on side 2 input");
  side3_avail_a: assert property (avail_whole_p(side3_i.avail))
    else $error("partial avail bits on side 3 input");
  bsk_avail_a: assert property (avail_whole_p(bsk_i.avail))
    else $error("partial avail bits on client batch");

  // --------------------------------------------------
  // Receiver flags
  // --------------------------------------------------
  done_vld_a: assert property (@(posedge clk) disable iff (reset_i) loop_done_i |-> bsk_vld_i)
    else $error("loop end pulse without a valid batch");
  err_vld_a: assert property (@(posedge clk) disable iff (reset_i) loop_err_i |-> bsk_vld_i)
    else $error("loop error pulse without a valid batch");

endmodule

bind bsk_ntw_top bsk_ntw_asserts i_bsk_ntw_asserts (
  .clk         (clk),
  .reset_i     (reset_i),
  .srv_pkt_i   (srv_pkt),
  .side2_i     (side2_i),
  .side3_i     (side3_i),
  .bsk_i       (bsk_o),
  .bsk_vld_i   (bsk_vld_o),
  .loop_done_i (loop_done_o),
  .loop_err_i  (loop_err_o)
);

// ==== dv/bsk_ntw_tb.sv ====
`timescale 1ns/100ps
`include "bsk_ntw_defines.svh"

module bsk_ntw_tb
  import param_tfhe_pkg::*;
  import bsk_ntw_common_param_pkg::*;
();

  localparam int          CLK_PERIOD = 100;
  localparam int          RESET_CYC  = 8;
  localparam int          WD_MARGIN  = 50;
  localparam logic [31:0] SEED       = 32'd46;
  localparam int          BATCH_W    = `BSK_BATCH_NB_W;
  localparam int          UNIT_NB    = 2 ** `BSK_UNIT_W;
  localparam int          GROUP_NB   = 2 ** `BSK_GROUP_W;

  typedef logic [`BSK_DIST_COEF_NB-1:0][`BSK_OP_W-1:0] batch_t;

  // Side outputs due 3 cycles after the command
  typedef struct packed {
    int       due;
    bsk_pkt_t side2;
    bsk_pkt_t side3;
  } side_exp_t;

  // Client outputs due 5 cycles after the command
  typedef struct packed {
    int                 due;
    bsk_pkt_t           pkt;
    logic               vld;
    logic               done;
    logic               err;
    logic [BATCH_W-1:0] nb;
  } client_exp_t;

  logic               clk = 1'b0;
  logic               reset_i;
  bsk_cmd_t           cmd_i;
  bsk_pkt_t           side2_i;
  bsk_pkt_t           side3_i;
  bsk_pkt_t           side2_o;
  bsk_pkt_t           side3_o;
  bsk_pkt_t           bsk_o;
  logic               bsk_vld_o;
  logic               loop_done_o;
  logic               loop_err_o;
  logic [BATCH_W-1:0] loop_batch_nb_o;

  bsk_ntw_top i_bsk_ntw_top (
    .clk             (clk),
    .reset_i         (reset_i),
    .cmd_i           (cmd_i),
    .side2_i         (side2_i),
    .side3_i         (side3_i),
    .side2_o         (side2_o),
    .side3_o         (side3_o),
    .bsk_o           (bsk_o),
    .bsk_vld_o       (bsk_vld_o),
    .loop_done_o     (loop_done_o),
    .loop_err_o      (loop_err_o),
    .loop_batch_nb_o (loop_batch_nb_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // Model state
  // --------------------------------------------------
  logic [31:0]        rng_state;
  bsk_cmd_t           cmd_list [$];
  batch_t             key_mem [UNIT_NB][GROUP_NB];
  side_exp_t          side_q [$];
  client_exp_t        client_q [$];
  // Remote region streams for the next cycle
  bsk_pkt_t           pend2;
  bsk_pkt_t           pend3;
  logic               m_active;
  lwe_k_t             m_loop;
  logic [BATCH_W-1:0] m_cnt;
  int                 cyc;
  int                 cmd_nb;
  int                 done_seen;
  int                 err_seen;
  logic               stim_ready;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic stop_on_error();
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pkt(input string name, input bsk_pkt_t exp_pkt,
                           input bsk_pkt_t got_pkt);
    assert (got_pkt === exp_pkt) else begin
      $display("error: %s expected %h got %h", name, exp_pkt, got_pkt);
      stop_on_error();
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    assert (got_v === exp_v) else begin
      $display("error: %s expected %h got %h", name, exp_v, got_v);
      stop_on_error();
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic add_cmd(input bsk_op_e op, input int unit, input int group,
                         input lwe_k_t br_loop);
    bsk_cmd_t c;
    c = '0;
    c.op = op;
    c.unit = `BSK_UNIT_W'(unit);
    c.group = `BSK_GROUP_W'(group);
    c.br_loop = br_loop;
    if (op == BSK_OP_LOAD) begin
      for (int i = 0; i < `BSK_DIST_COEF_NB; i++) begin
        c.coef[i] = next_rand();
      end
    end
    cmd_list.push_back(c);
  endtask

  task automatic add_idle(input int n);
    repeat (n) add_cmd(BSK_OP_IDLE, 0, 0, '0);
  endtask

  // Random broadcasts with idle and load gaps that never hit the last slot
  task automatic add_sweep(input lwe_k_t br_loop, input int nb);
    logic [31:0] r;
    int          u;
    int          g;
    repeat (nb) begin
      r = next_rand();
      u = int'(r[1:0]);
      g = int'(r[4:2]);
      if (u == UNIT_NB - 1 && g == GROUP_NB - 1) begin
        g = 0;
      end
      add_cmd(BSK_OP_BCAST, u, g, br_loop);
      case (r[9:8])
        2'd0: add_idle(1);
        2'd1: add_cmd(BSK_OP_LOAD, int'(r[11:10]), int'(r[14:12]), br_loop);
        default: ;
      endcase
    end
  endtask

  task automatic build_stimulus();
    logic [31:0] r;
    lwe_k_t      la;
    lwe_k_t      lb;
    lwe_k_t      lc;
    add_idle(2);
    for (int u = 0; u < UNIT_NB; u++) begin
      for (int g = 0; g < GROUP_NB; g++) begin
        add_cmd(BSK_OP_LOAD, u, g, '0);
        r = next_rand();
        if (r[1:0] == 2'd0) add_idle(1);
      end
    end
    r = next_rand();
    la = r[3:0];
    lb = r[7:4];
    // Nonzero offset so the index really changes
    lc = lb + lwe_k_t'({1'b0, r[10:8]}) + lwe_k_t'(1);
    add_sweep(la, 20);
    add_cmd(BSK_OP_BCAST, UNIT_NB - 1, GROUP_NB - 1, la);
    add_idle(3);
    add_sweep(lb, 6);
    add_sweep(lc, 4);
    add_cmd(BSK_OP_BCAST, UNIT_NB - 1, GROUP_NB - 1, lc);
    add_idle(8);
  endtask

  // --------------------------------------------------
  // Expected values
  // --------------------------------------------------
  task automatic model_cycle(input bsk_cmd_t cmd);
    bsk_pkt_t    pkt;
    side_exp_t   se;
    client_exp_t ce;
    logic        restart;
    pkt = '0;
    se = '0;
    ce = '0;
    pend2 = '0;
    pend3 = '0;
    se.due = cyc + 3;
    ce.due = cyc + 5;
    if (cmd.op == BSK_OP_LOAD) key_mem[cmd.unit][cmd.group] = cmd.coef;
    if (cmd.op == BSK_OP_BCAST) begin
      pkt.coef = key_mem[cmd.unit][cmd.group];
      pkt.avail = '1;
      pkt.unit = cmd.unit;
      pkt.group = cmd.group;
      pkt.br_loop = cmd.br_loop;
      // Owner is group modulo 4
      // Remote owners go out on their own side only
      case (cmd.group[`BSK_OWNER_W-1:0])
        2'd2: begin
          se.side2 = pkt;
          pend2 = pkt;
        end
        2'd3: begin
          se.side3 = pkt;
          pend3 = pkt;
        end
        default: begin
          se.side2 = pkt;
          se.side3 = pkt;
        end
      endcase
      restart = !m_active || (cmd.br_loop != m_loop);
      ce.err = m_active && (cmd.br_loop != m_loop);
      m_cnt = restart ? BATCH_W'(1) : m_cnt + BATCH_W'(1);
      if (restart) m_loop = cmd.br_loop;
      ce.done = (cmd.unit == UNIT_NB - 1) && (cmd.group == GROUP_NB - 1);
      m_active = !ce.done;
      ce.pkt = pkt;
      ce.vld = 1'b1;
      ce.nb = m_cnt;
    end
    side_q.push_back(se);
    client_q.push_back(ce);
  endtask

  task automatic drive_inputs();
    bsk_cmd_t cmd;
    cmd = '0;
    reset_i = (cyc < RESET_CYC);
    side2_i = pend2;
    side3_i = pend3;
    if (cyc >= RESET_CYC && cmd_list.size() > 0) cmd = cmd_list.pop_front();
    cmd_i = cmd;
    model_cycle(cmd);
  endtask

  task automatic check_outputs();
    side_exp_t   se;
    client_exp_t ce;
    se = '0;
    ce = '0;
    if (side_q.size() > 0 && side_q[0].due == cyc) begin
      se = side_q.pop_front();
    end
    if (client_q.size() > 0 && client_q[0].due == cyc) begin
      ce = client_q.pop_front();
    end
    if (cyc >= RESET_CYC) begin
      check_pkt("side2_o", se.side2, side2_o);
      check_pkt("side3_o", se.side3, side3_o);
      check_pkt("bsk_o", ce.pkt, bsk_o);
      check_val("bsk_vld_o", 32'(ce.vld), 32'(bsk_vld_o));
      check_val("loop_done_o", 32'(ce.done), 32'(loop_done_o));
      check_val("loop_err_o", 32'(ce.err), 32'(loop_err_o));
      if (ce.done) check_val("loop_batch_nb_o", 32'(ce.nb), 32'(loop_batch_nb_o));
      if (loop_done_o === 1'b1) done_seen++;
      if (loop_err_o === 1'b1) err_seen++;
    end
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial begin
    reset_i = 1'b1;
    cmd_i = '0;
    side2_i = '0;
    side3_i = '0;
    pend2 = '0;
    pend3 = '0;
    m_active = 1'b0;
    m_loop = '0;
    m_cnt = '0;
    cyc = 0;
    done_seen = 0;
    err_seen = 0;
    stim_ready = 1'b0;
    rng_state = SEED;
    build_stimulus();
    cmd_nb = cmd_list.size();
    stim_ready = 1'b1;
    while (cyc < RESET_CYC + cmd_nb) begin
      @(posedge clk);
      cyc++;
      #1;
      check_outputs();
      drive_inputs();
    end
    // Two loop ends and one index change in the stream
    assert (done_seen == 2 && err_seen == 1) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("loop end or loop error pulses missing from the run");
      stop_on_error();
    end
  end

  initial begin
    wait (stim_ready === 1'b1);
    #((RESET_CYC + cmd_nb + WD_MARGIN) * CLK_PERIOD);
    $display("timeout: the command stream did not complete in time");
    stop_on_error();
  end

endmodule

// ==== flist.f ====
+incdir+include
design/param_tfhe_pkg.sv
design/bsk_ntw_common_param_pkg.sv
design/bsk_server.sv
design/bsk_inner_or_tree.sv
design/bsk_client_recv.sv
design/bsk_ntw_top.sv
dv/bsk_ntw_asserts.sv
dv/bsk_ntw_tb.sv

// ==== include/bsk_ntw_defines.svh ====
`ifndef BSK_NTW_DEFINES_SVH
`define BSK_NTW_DEFINES_SVH

// Batch geometry
`define BSK_DIST_COEF_NB 4
`define BSK_OP_W 32

// Key slot addressing
`define BSK_UNIT_W 2
`define BSK_GROUP_W 3

// Blind-rotation loop index
`define LWE_K_W 4

// Owner of a group is its low group bits (group modulo 4)
`define BSK_OWNER_W 2

// Servers inside this region
`define BSK_LOCAL_SRV_NB 2

// Batch counter, one bit above a full unit and group sweep
`define BSK_BATCH_NB_W (`BSK_UNIT_W + `BSK_GROUP_W + 1)

`endif
